// ==== flist.f ====
+incdir+tb
logic/kinpira_pkg.sv
logic/layer_regs.sv
logic/img_buf.sv
logic/dense_engine.sv
logic/kinpira_top.sv
tb/tb_kinpira.sv

// ==== logic/dense_engine.sv ====
`default_nettype none

module dense_engine import kinpira_pkg::*; (
  input  logic               clk,
  input  logic               xrst,
  input  logic               req,
  input  layer_cfg_t         cfg,
  input  logic               net_we,
  input  logic [NETSIZE-1:0] net_addr,
  input  logic [DWIDTH-1:0]  net_wdata,
  input  logic [DWIDTH-1:0]  img_rdata,
  output mem_port_t          eng_port,
  output logic               busy,
  output logic               ack
);

  typedef enum logic [2:0] {S_IDLE, S_BIAS, S_MAC, S_DRAIN, S_WRITE} state_t;

  state_t                     state;
  logic [LWIDTH-1:0]          in_cnt;
  logic [LWIDTH-1:0]          out_cnt;
  logic [NETSIZE-1:0]         net_ptr;
  logic [DWIDTH-1:0]          net_mem [0:2**NETSIZE-1];
  logic signed [DWIDTH-1:0]   net_rdata;
  logic signed [2*DWIDTH-1:0] prod;
  logic signed [ACCWIDTH-1:0] acc;
  logic signed [ACCWIDTH-1:0] scaled;
  logic signed [DWIDTH-1:0]   sat;
  logic signed [DWIDTH-1:0]   result;
  logic                       last_in;
  logic                       last_out;

  //====================
  // Network memory
  //====================
  always_ff @(posedge clk) begin
    if (net_we) begin
      net_mem[net_addr] <= net_wdata;
    end
    net_rdata <= $signed(net_mem[net_ptr]);
  end

  //====================
  // Control
  //====================
  assign last_in  = in_cnt == cfg.total_in - LWIDTH'(1);
  assign last_out = out_cnt == cfg.total_out - LWIDTH'(1);
  assign busy     = state != S_IDLE;

  // Neuron blocks are contiguous, so net_ptr just counts up
  always_ff @(posedge clk) begin
    if (!xrst) begin
      state   <= S_IDLE;
      ack     <= 1'b0;
      in_cnt  <= '0;
      out_cnt <= '0;
      net_ptr <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (req) begin
            state   <= S_BIAS;
            ack     <= 1'b0;
            out_cnt <= '0;
            net_ptr <= cfg.net_offset;
          end
        end
        S_BIAS: begin
          state   <= S_MAC;
          in_cnt  <= '0;
          net_ptr <= net_ptr + 1'b1;
        end
        S_MAC: begin
          in_cnt  <= in_cnt + 1'b1;
          net_ptr <= net_ptr + 1'b1;
          if (last_in) begin
            state <= S_DRAIN;
          end
        end
        S_DRAIN: state <= S_WRITE;
        S_WRITE: begin
          if (last_out) begin
            state <= S_IDLE;
            ack   <= 1'b1;
          end else begin
            state   <= S_BIAS;
            out_cnt <= out_cnt + 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  //====================
  // Datapath
  //====================
  // Operands arrive one cycle after their reads
  assign prod = net_rdata * $signed(img_rdata);

  always_ff @(posedge clk) begin
    if (state == S_MAC && in_cnt == '0) begin
      // Bias word lands on the first MAC cycle
      if (cfg.bias_en) begin
        acc <= net_rdata;
      end else begin
        acc <= '0;
      end
    end else if (state == S_MAC || state == S_DRAIN) begin
      acc <= acc + prod;
    end
  end

  assign scaled = acc >>> FRAC;

  always_comb begin
    if (scaled > DMAX) begin
      sat = DWIDTH'(DMAX);
    end else if (scaled < DMIN) begin
      sat = DWIDTH'(DMIN);
    end else begin
      sat = scaled[DWIDTH-1:0];
    end
    result = (cfg.relu_en && sat[DWIDTH-1]) ? '0 : sat;
  end

  // Image reads while accumulating, one write per neuron
  always_comb begin
    eng_port.we    = state == S_WRITE;
    eng_port.addr  = cfg.in_offset + MEMSIZE'(in_cnt);
    eng_port.wdata = result;
    if (state == S_WRITE) begin
      eng_port.addr = cfg.out_offset + MEMSIZE'(out_cnt);
    end
  end

  a_req_idle: assert property (@(posedge clk) disable iff (!xrst) req |-> !busy)
    else $error("layer request while engine busy");

  a_req_size: assert property (@(posedge clk) disable iff (!xrst)
    req |-> cfg.total_in != '0)
    else $error("layer request with zero inputs");

  a_net_idle: assert property (@(posedge clk) disable iff (!xrst) net_we |-> !busy)
    else $error("network memory write while engine busy");

endmodule

`default_nettype wire

// ==== logic/img_buf.sv ====
`default_nettype none

module img_buf import kinpira_pkg::*; (
  input  logic              clk,
  input  logic              busy,
  input  mem_port_t         host_port,
  input  mem_port_t         eng_port,
  output logic [DWIDTH-1:0] img_rdata
);

  logic [DWIDTH-1:0] mem [0:2**MEMSIZE-1];
  mem_port_t         port;

  // Engine owns the buffer while a layer runs
  assign port = busy ? eng_port : host_port;

  //====================
  // Single-port memory
  //====================
  always_ff @(posedge clk) begin
    if (port.we) begin
      mem[port.addr] <= port.wdata;
    end
  end

  // Registered read, old data on a write
  always_ff @(posedge clk) begin
    img_rdata <= mem[port.addr];
  end

  // Host writes during a layer would be lost
  a_host_idle: assert property (@(posedge clk) busy |-> !host_port.we)
    else $error("host write to image buffer while engine busy");

endmodule

`default_nettype wire

// ==== logic/kinpira_pkg.sv ====
`default_nettype none

package kinpira_pkg;

  //====================
  // Widths
  //====================
  localparam int BWIDTH   = 32;
  localparam int DWIDTH   = 16;
  localparam int MEMSIZE  = 10;
  localparam int NETSIZE  = 10;
  localparam int LWIDTH   = 10;
  localparam int REGSIZE  = 5;
  localparam int ACCWIDTH = 40;

  // Fixed point, fractional bits
  localparam int FRAC = 8;

  // Saturation limits of a data word
  localparam int DMAX = (1 << (DWIDTH - 1)) - 1;
  localparam int DMIN = -(1 << (DWIDTH - 1));

  //====================
  // Register map
  //====================
  localparam int REG_REQ        = 1;
  localparam int REG_IN_OFFSET  = 2;
  localparam int REG_OUT_OFFSET = 3;
  localparam int REG_NET_OFFSET = 4;
  // total_out above bit LWIDTH, total_in below
  localparam int REG_BASE       = 9;
  // Enables live in the top bit
  localparam int REG_BIAS       = 13;
  localparam int REG_ACTV       = 14;

  //====================
  // Shared types
  //====================
  typedef struct packed {
    logic [MEMSIZE-1:0] in_offset;
    logic [MEMSIZE-1:0] out_offset;
    logic [NETSIZE-1:0] net_offset;
    logic [LWIDTH-1:0]  total_out;
    logic [LWIDTH-1:0]  total_in;
    logic               bias_en;
    logic               relu_en;
  } layer_cfg_t;

  // One access to the image buffer
  typedef struct packed {
    logic               we;
    logic [MEMSIZE-1:0] addr;
    logic [DWIDTH-1:0]  wdata;
  } mem_port_t;

endpackage

`default_nettype wire

// ==== logic/kinpira_top.sv ====
`default_nettype none

module kinpira_top import kinpira_pkg::*; (
  input  logic               clk,
  input  logic               xrst,
  input  logic               reg_we,
  input  logic [REGSIZE-1:0] reg_addr,
  input  logic [BWIDTH-1:0]  reg_wdata,
  input  mem_port_t          host_port,
  output logic [DWIDTH-1:0]  img_rdata,
  input  logic               net_we,
  input  logic [NETSIZE-1:0] net_addr,
  input  logic [DWIDTH-1:0]  net_wdata,
  output logic               busy,
  output logic               ack
);

  layer_cfg_t cfg;
  logic       req;
  mem_port_t  eng_port;

  //====================
  // Parameter words
  //====================
  layer_regs regs0 (
    .clk       (clk),
    .xrst      (xrst),
    .reg_we    (reg_we),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .cfg       (cfg),
    .req       (req)
  );

  //====================
  // Image buffer
  //====================
  img_buf buf0 (
    .clk       (clk),
    .busy      (busy),
    .host_port (host_port),
    .eng_port  (eng_port),
    .img_rdata (img_rdata)
  );

  //====================
  // Dense layer
  //====================
  dense_engine engine0 (
    .clk       (clk),
    .xrst      (xrst),
    .req       (req),
    .cfg       (cfg),
    .net_we    (net_we),
    .net_addr  (net_addr),
    .net_wdata (net_wdata),
    .img_rdata (img_rdata),
    .eng_port  (eng_port),
    .busy      (busy),
    .ack       (ack)
  );

endmodule

`default_nettype wire

// ==== logic/layer_regs.sv ====
`default_nettype none

module layer_regs import kinpira_pkg::*; (
  input  logic               clk,
  input  logic               xrst,
  input  logic               reg_we,
  input  logic [REGSIZE-1:0] reg_addr,
  input  logic [BWIDTH-1:0]  reg_wdata,
  output layer_cfg_t         cfg,
  output logic               req
);

  logic [BWIDTH-1:0] params [0:2**REGSIZE-1];
  logic              req_write;

  //====================
  // Parameter bank
  //====================

  // Request slot is a trigger only
  assign req_write = reg_we && (reg_addr == REGSIZE'(REG_REQ));

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < 2**REGSIZE; i++) begin
        params[i] <= '0;
      end
    end else if (reg_we && !req_write) begin
      params[reg_addr] <= reg_wdata;
    end
  end

  // One-cycle start pulse
  always_ff @(posedge clk) begin
    if (!xrst) begin
      req <= 1'b0;
    end else begin
      req <= req_write && reg_wdata[0];
    end
  end

  //====================
  // Field decode
  //====================
  always_comb begin
    cfg.in_offset  = params[REG_IN_OFFSET][MEMSIZE-1:0];
    cfg.out_offset = params[REG_OUT_OFFSET][MEMSIZE-1:0];
    cfg.net_offset = params[REG_NET_OFFSET][NETSIZE-1:0];
    // Layer sizes share one word
    cfg.total_out  = params[REG_BASE][2*LWIDTH-1:LWIDTH];
    cfg.total_in   = params[REG_BASE][LWIDTH-1:0];
    cfg.bias_en    = params[REG_BIAS][BWIDTH-1];
    cfg.relu_en    = params[REG_ACTV][BWIDTH-1];
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the dense layer testbench with Verilator

BUILD=build
LOG=$BUILD/sim.log

if ! mkdir -p "$BUILD"; then
  echo "Cannot create $BUILD"
  exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_kinpira \
    --Mdir "$BUILD/obj" -o vsim -f flist.f; then
  echo "Verilator build failed"
  exit 1
fi

"$BUILD/obj/vsim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

grep -qx "Regression passed" "$LOG"
exit $?

// ==== tb/layer_model.svh ====
`ifndef LAYER_MODEL_SVH
`define LAYER_MODEL_SVH

// Rescale by FRAC, then clamp to a signed data word
function automatic logic signed [DWIDTH-1:0] rescale_clamp(input longint acc);
  longint scaled;
  longint hi;
  longint lo;
  hi = (longint'(1) <<< (DWIDTH - 1)) - 1;
  lo = -(longint'(1) <<< (DWIDTH - 1));
  scaled = acc >>> FRAC;
  if (scaled > hi) begin
    scaled = hi;
  end else if (scaled < lo) begin
    scaled = lo;
  end
  return DWIDTH'(scaled);
endfunction

// Neuron o owns the block at net_offset + o*(total_in+1), bias word first
function automatic logic signed [DWIDTH-1:0] neuron_out(input layer_row_t row, input int o);
  longint acc;
  int base;
  logic signed [DWIDTH-1:0] y;
  base = row.net_offset + o * (row.total_in + 1);
  acc = 0;
  if (row.bias_en != 0) begin
    acc = longint'(net_model[base]);
  end
  for (int i = 0; i < row.total_in; i++) begin
    acc += longint'(net_model[base + 1 + i]) * longint'(img_model[row.in_offset + i]);
  end
  y = rescale_clamp(acc);
  if (row.relu_en != 0 && y < 0) begin
    y = '0;
  end
  return y;
endfunction

`endif

// ==== tb/tb_kinpira.sv ====
`default_nettype none

module tb_kinpira import kinpira_pkg::*;;

  typedef struct packed {
    int total_in;
    int total_out;
    int in_offset;
    int out_offset;
    int net_offset;
    int bias_en;
    int relu_en;
    int img_span;
    int w_span;
    int seed_ofs;
  } layer_row_t;

  localparam int NUM_ROWS  = 6;
  localparam int SEED      = 54921;
  localparam int BIAS_SPAN = 8000;

  logic               clk = 1'b0;
  logic               xrst;
  logic               reg_we;
  logic [REGSIZE-1:0] reg_addr;
  logic [BWIDTH-1:0]  reg_wdata;
  mem_port_t          host_port;
  logic [DWIDTH-1:0]  img_rdata;
  logic               net_we;
  logic [NETSIZE-1:0] net_addr;
  logic [DWIDTH-1:0]  net_wdata;
  logic               busy;
  logic               ack;
  logic               ack_prev = 1'b0;

  layer_row_t               rows [0:NUM_ROWS-1];
  logic signed [DWIDTH-1:0] img_model [0:2**MEMSIZE-1];
  logic signed [DWIDTH-1:0] net_model [0:2**NETSIZE-1];
  int seed = SEED;
  int mismatch_count = 0;
  int other_count = 0;
  int ack_rises = 0;
  int cycle_count = 0;
  int cycle_limit;

  `include "layer_model.svh"

  kinpira_top dut0 (
    .clk       (clk),
    .xrst      (xrst),
    .reg_we    (reg_we),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .host_port (host_port),
    .img_rdata (img_rdata),
    .net_we    (net_we),
    .net_addr  (net_addr),
    .net_wdata (net_wdata),
    .busy      (busy),
    .ack       (ack)
  );

  always #4 clk = ~clk;

  // Count ack rising edges away from the clock edge
  always @(negedge clk) begin
    if (xrst && ack && !ack_prev) begin
      ack_rises++;
    end
    ack_prev = ack;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count + 1);
      $display("Regression failed");
      $finish;
    end
  end

  //====================
  // Host access
  //====================
  task automatic write_reg(input int addr, input int data);
    reg_we    = 1'b1;
    reg_addr  = REGSIZE'(addr);
    reg_wdata = BWIDTH'(data);
    @(posedge clk);
    #1;
    reg_we = 1'b0;
  endtask

  task automatic load_word(input bit to_net, input int addr, input int data);
    host_port.we    = !to_net;
    host_port.addr  = MEMSIZE'(addr);
    host_port.wdata = DWIDTH'(data);
    net_we          = to_net;
    net_addr        = NETSIZE'(addr);
    net_wdata       = DWIDTH'(data);
    @(posedge clk);
    #1;
    host_port.we = 1'b0;
    net_we       = 1'b0;
  endtask

  task automatic check_img(input int addr, input logic [DWIDTH-1:0] exp);
    host_port.addr = MEMSIZE'(addr);
    @(posedge clk);
    #1;
    assert (img_rdata === exp) else begin
      mismatch_count++;
      $display("Mismatch at time %0t: image word %0d read %0d, expected %0d",
        $time, addr, $signed(img_rdata), $signed(exp));
    end
  endtask

  task automatic wait_done(input int limit);
    int waited;
    bit started;
    waited  = 0;
    started = 1'b0;
    while (!(started && ack && !busy) && waited < limit) begin
      @(posedge clk);
      #1;
      waited++;
      started = started || busy;
      assert (!(busy && ack)) else begin
        mismatch_count++;
        $display("Mismatch at time %0t: ack high while busy", $time);
      end
    end
    assert (started && ack && !busy) else begin
      other_count++;
      $display("Engine did not finish the layer within %0d cycles", limit);
    end
  endtask

  function automatic int random_word(input int span);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return r % (2 * span + 1) - span;
  endfunction

  // Engine cycles plus loads, register writes, readback and margin
  function automatic int run_budget();
    int total;
    total = 20;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total += rows[r].total_out * (2 * rows[r].total_in + 5);
      total += 2 * rows[r].total_in + rows[r].total_out + 12;
    end
    return total + total / 4 + 100;
  endfunction

  //====================
  // One layer
  //====================
  task automatic run_layer(input layer_row_t row);
    int v;
    int rises_before;
    seed = SEED + row.seed_ofs;
    for (int i = 0; i < row.total_in; i++) begin
      v = random_word(row.img_span);
      img_model[row.in_offset + i] = DWIDTH'(v);
      load_word(1'b0, row.in_offset + i, v);
    end
    for (int k = 0; k < row.total_out * (row.total_in + 1); k++) begin
      // Wide bias words move the rescaled result by many steps
      if (k % (row.total_in + 1) == 0) begin
        v = random_word(BIAS_SPAN);
      end else begin
        v = random_word(row.w_span);
      end
      net_model[row.net_offset + k] = DWIDTH'(v);
      load_word(1'b1, row.net_offset + k, v);
    end
    write_reg(REG_IN_OFFSET, row.in_offset);
    write_reg(REG_OUT_OFFSET, row.out_offset);
    write_reg(REG_NET_OFFSET, row.net_offset);
    write_reg(REG_BASE, (row.total_out << LWIDTH) | row.total_in);
    write_reg(REG_BIAS, row.bias_en << (BWIDTH - 1));
    write_reg(REG_ACTV, row.relu_en << (BWIDTH - 1));
    rises_before = ack_rises;
    write_reg(REG_REQ, 1);
    wait_done(row.total_out * (row.total_in + 3) + 8);
    for (int o = 0; o < row.total_out; o++) begin
      check_img(row.out_offset + o, neuron_out(row, o));
    end
    // Inputs must survive the layer
    for (int i = 0; i < row.total_in; i++) begin
      check_img(row.in_offset + i, img_model[row.in_offset + i]);
    end
    assert (ack_rises == rises_before + 1) else begin
      mismatch_count++;
      $display("Mismatch at time %0t: ack rose %0d times for one request",
        $time, ack_rises - rises_before);
    end
  endtask

  initial begin
    xrst      = 1'b0;
    reg_we    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    host_port = '0;
    net_we    = 1'b0;
    net_addr  = '0;
    net_wdata = '0;
    // in, out, in_off, out_off, net_off, bias, relu, img span, w span, seed
    rows[0] = '{6, 4, 0, 32, 0, 1, 0, 100, 100, 0};
    rows[1] = '{5, 6, 16, 64, 40, 1, 1, 120, 120, 1};
    rows[2] = '{4, 5, 8, 48, 100, 1, 0, 2000, 30000, 2};
    rows[3] = '{7, 3, 100, 200, 300, 0, 0, 100, 100, 3};
    rows[4] = '{3, 8, 500, 510, 700, 1, 1, 90, 90, 4};
    rows[5] = '{1, 2, 900, 950, 1000, 1, 0, 200, 200, 5};
    cycle_limit = run_budget();
    repeat (4) @(posedge clk);
    #1;
    xrst = 1'b1;
    @(posedge clk);
    #1;
    assert (!ack && !busy) else begin
      mismatch_count++;
      $display("Mismatch at time %0t: ack or busy high after reset", $time);
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_layer(rows[r]);
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
